/* hw/cbus_pkg.sv */
`default_nettype none

package cbus_pkg;

    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = 4;
    localparam int len_width  = 4;   // beats minus one.

    localparam logic [1:0] axi_burst_wrap = 2'b10;
    localparam logic [2:0] axi_size_word  = 3'b010;   // 4 bytes per beat.

    typedef logic [len_width-1:0] mlen_t;

    // request as held by a cache bus master.
    typedef struct packed {
        logic                  valid;
        logic                  is_write;
        logic [2:0]            size;
        logic [addr_width-1:0] addr;
        logic [strb_width-1:0] strobe;
        logic [data_width-1:0] data;
        mlen_t                 len;
    } cbus_req_t;

    typedef struct packed {
        logic                  ready;   // one beat done.
        logic                  last;    // final beat done.
        logic [data_width-1:0] data;
    } cbus_resp_t;

    // master side of the AXI3 port.
    typedef struct packed {
        logic [3:0]            arid;
        logic [addr_width-1:0] araddr;
        mlen_t                 arlen;
        logic [2:0]            arsize;
        logic [1:0]            arburst;
        logic                  arvalid;
        logic                  rready;
        logic [3:0]            awid;
        logic [addr_width-1:0] awaddr;
        mlen_t                 awlen;
        logic [2:0]            awsize;
        logic [1:0]            awburst;
        logic                  awvalid;
        logic [3:0]            wid;
        logic [data_width-1:0] wdata;
        logic [strb_width-1:0] wstrb;
        logic                  wlast;
        logic                  wvalid;
        logic                  bready;
    } axi_req_t;

    // slave side of the AXI3 port.
    typedef struct packed {
        logic                  arready;
        logic [3:0]            rid;
        logic [data_width-1:0] rdata;
        logic [1:0]            rresp;
        logic                  rlast;
        logic                  rvalid;
        logic                  awready;
        logic                  wready;
        logic [3:0]            bid;
        logic [1:0]            bresp;
        logic                  bvalid;
    } axi_resp_t;

endpackage

`default_nettype wire

/* hw/cbus_arbiter.sv */
`default_nettype none

// two cache bus masters share one cache bus.
// index 0 is the instruction master, index 1 the data master.
module cbus_arbiter (
    input  logic                 aclk,
    input  logic                 aresetn,

    input  cbus_pkg::cbus_req_t  ireq,
    input  cbus_pkg::cbus_req_t  dreq,
    output cbus_pkg::cbus_resp_t iresp,
    output cbus_pkg::cbus_resp_t dresp,

    output cbus_pkg::cbus_req_t  creq,
    input  cbus_pkg::cbus_resp_t cresp
);
    logic locked_q;   // a transaction owns the bus.
    logic grant_q;    // owner while locked.
    logic prio_q;     // who goes first when unlocked.

    logic pick;       // choice among pending masters.
    logic sel;        // index that drives creq.

    // round robin between the two valids.
    // with nothing pending the pick stays on the priority side.
    always_comb begin
        if (prio_q) begin
            pick = dreq.valid || !ireq.valid;
        end else begin
            pick = !ireq.valid && dreq.valid;
        end
    end

    assign sel = locked_q ? grant_q : pick;

    // request mux.
    always_comb begin
        if (sel) begin
            creq = dreq;
        end else begin
            creq = ireq;
        end
    end

    // response demux.
    // only the owner of a locked grant sees anything.
    always_comb begin
        iresp = '0;
        dresp = '0;

        if (locked_q) begin
            if (grant_q) begin
                dresp = cresp;
            end else begin
                iresp = cresp;
            end
        end
    end

    // lock on the first cycle the chosen valid is seen,
    // release on the edge after the final beat.
    always_ff @(posedge aclk) begin
        if (aresetn) begin
            locked_q <= 1'b0;
            grant_q  <= 1'b0;
            prio_q   <= 1'b0;   // instruction side first.
        end else if (locked_q) begin
            if (cresp.last) begin
                locked_q <= 1'b0;
                prio_q   <= !grant_q;   // the other one goes next.
            end
        end else if (creq.valid) begin
            locked_q <= 1'b1;
            grant_q  <= pick;
        end
    end

endmodule

`default_nettype wire

/* hw/cbus_to_axi.sv */
`default_nettype none

// converts one cache bus transaction at a time into AXI3 traffic.
// a request is taken only while idle, so latency to the address valid is one cycle.
module cbus_to_axi (
    input  logic                 aclk,
    input  logic                 aresetn,

    input  cbus_pkg::cbus_req_t  creq,
    output cbus_pkg::cbus_resp_t cresp,

    output cbus_pkg::axi_req_t   axi_req,
    input  cbus_pkg::axi_resp_t  axi_resp
);
    // one flag per AXI channel still owed a handshake.
    typedef struct packed {
        logic ar;
        logic r;
        logic aw;
        logic w;
        logic b;
    } issue_t;

    issue_t in_issue;
    issue_t next_issue;
    issue_t done;       // channels finishing this cycle.
    issue_t remain;

    logic                            busy;
    logic                            is_last;
    logic                            beat_r;
    logic                            beat_w;
    logic                            rready;
    logic                            bready;

    logic [cbus_pkg::addr_width-1:0] saved_addr;
    logic [2:0]                      saved_size;
    cbus_pkg::mlen_t                 saved_len;
    cbus_pkg::mlen_t                 beats_left;   // zero on the final beat.

    assign busy    = |in_issue;
    assign is_last = beats_left == '0;

    // reads open AR and R, writes open AW, W and B.
    always_comb begin
        next_issue = '0;
        if (creq.is_write) begin
            next_issue.aw = 1'b1;
            next_issue.w  = 1'b1;
            next_issue.b  = 1'b1;
        end else begin
            next_issue.ar = 1'b1;
            next_issue.r  = 1'b1;
        end
    end

    // R waits for the address, B for all of the data.
    assign rready = in_issue.r && !in_issue.ar;
    assign bready = in_issue.b && !in_issue.aw && !in_issue.w;

    assign beat_r = rready && axi_resp.rvalid;
    assign beat_w = in_issue.w && axi_resp.wready;

    always_comb begin
        done.ar = in_issue.ar && axi_resp.arready;
        done.r  = beat_r && axi_resp.rlast;
        done.aw = in_issue.aw && axi_resp.awready;
        done.w  = beat_w && is_last;
        done.b  = bready && axi_resp.bvalid;
    end

    assign remain = in_issue & ~done;

    // cache bus side.
    assign cresp.ready = beat_r || beat_w;
    assign cresp.last  = cresp.ready && is_last && (!beat_r || axi_resp.rlast);
    assign cresp.data  = axi_resp.rdata;

    // AXI side; quiet channels stay at zero.
    always_comb begin
        axi_req = '0;

        if (in_issue.ar) begin
            axi_req.arvalid = 1'b1;
            axi_req.araddr  = saved_addr;
            axi_req.arlen   = saved_len;
            axi_req.arsize  = saved_size;
            axi_req.arburst = cbus_pkg::axi_burst_wrap;
        end

        axi_req.rready = rready;

        if (in_issue.aw) begin
            axi_req.awvalid = 1'b1;
            axi_req.awaddr  = saved_addr;
            axi_req.awlen   = saved_len;
            axi_req.awsize  = saved_size;
            axi_req.awburst = cbus_pkg::axi_burst_wrap;
        end

        // write data follows the master beat by beat.
        if (in_issue.w) begin
            axi_req.wvalid = 1'b1;
            axi_req.wdata  = creq.data;
            axi_req.wstrb  = creq.strobe;
            axi_req.wlast  = is_last;
        end

        axi_req.bready = bready;
    end

    always_ff @(posedge aclk) begin
        if (aresetn) begin
            in_issue   <= '0;
            beats_left <= '0;
        end else if (busy) begin
            in_issue <= remain;
            if (cresp.ready && !is_last) begin
                beats_left <= beats_left - cbus_pkg::mlen_t'(1);
            end
        end else if (creq.valid) begin
            in_issue   <= next_issue;
            beats_left <= creq.len;
        end
    end

    // address phase fields, held for the whole transaction.
    always_ff @(posedge aclk) begin
        if (!busy && creq.valid) begin
            saved_addr <= creq.addr;
            saved_size <= creq.size;
            saved_len  <= creq.len;
        end
    end

endmodule

`default_nettype wire

/* hw/cbus_axi_top.sv */
`default_nettype none

// two cache bus masters onto one AXI3 master port.
module cbus_axi_top (
    input  logic                 aclk,
    input  logic                 aresetn,

    // instruction side, reads only.
    input  cbus_pkg::cbus_req_t  ireq,
    output cbus_pkg::cbus_resp_t iresp,

    // data side.
    input  cbus_pkg::cbus_req_t  dreq,
    output cbus_pkg::cbus_resp_t dresp,

    output cbus_pkg::axi_req_t   axi_req,
    input  cbus_pkg::axi_resp_t  axi_resp
);
    cbus_pkg::cbus_req_t  creq;    // granted request.
    cbus_pkg::cbus_resp_t cresp;

    cbus_arbiter cbus_arbiter_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .ireq    (ireq),
        .dreq    (dreq),
        .iresp   (iresp),
        .dresp   (dresp),
        .creq    (creq),
        .cresp   (cresp)
    );

    // one transaction in flight.
    cbus_to_axi cbus_to_axi_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .creq     (creq),
        .cresp    (cresp),
        .axi_req  (axi_req),
        .axi_resp (axi_resp)
    );

endmodule

`default_nettype wire

/* verification/axi_mem_model.sv */
`default_nettype none

// AXI3 slave memory for the testbench.
// one read burst and one write burst at a time, wrap addressing, random stalls.
module axi_mem_model (
    input  logic                aclk,
    input  logic                aresetn,
    input  cbus_pkg::axi_req_t  axi_req,
    output cbus_pkg::axi_resp_t axi_resp
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] mem [logic [29:0]];   // word addressed, sparse.

    cbus_pkg::axi_resp_t nxt;
    logic                rd_busy;
    logic                wr_busy;
    logic                b_due;       // write done, response not offered yet.
    logic [31:0]         rd_addr;
    logic [31:0]         wr_addr;
    cbus_pkg::mlen_t     rd_len;
    cbus_pkg::mlen_t     rd_left;
    cbus_pkg::mlen_t     wr_len;

    initial begin
        void'($urandom(32'h802f0b10));
    end

    // three cycles in four go ahead.
    function automatic logic no_stall();
        return ($urandom % 4) != 0;
    endfunction

    // next beat inside a wrap boundary of len+1 words.
    function automatic logic [31:0] wrap_step(input logic [31:0] a, input cbus_pkg::mlen_t len);
        logic [31:0] span;
        span = (32'(len) + 1) * 4;
        return (a & ~(span - 1)) | ((a + 4) & (span - 1));
    endfunction

    // unwritten words give a pattern of the whole address.
    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (mem.exists(a[31:2])) begin
            return mem[a[31:2]];
        end
        return {a[15:0], ~a[31:16]};
    endfunction

    function automatic void write_word(input logic [31:0] a, input logic [31:0] d,
                                       input logic [3:0] strb);
        logic [31:0] w;
        w = read_word(a);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                w[i*8 +: 8] = d[i*8 +: 8];
            end
        end
        mem[a[31:2]] = w;
    endfunction

    always @(posedge aclk) begin
        nxt = axi_resp;
        if (aresetn) begin
            nxt     = '0;
            rd_busy = 1'b0;
            wr_busy = 1'b0;
            b_due   = 1'b0;
        end else begin
            if (axi_resp.arready && axi_req.arvalid) begin
                rd_busy = 1'b1;
                rd_addr = axi_req.araddr;
                rd_len  = axi_req.arlen;
                rd_left = axi_req.arlen;
            end
            if (axi_resp.rvalid && axi_req.rready) begin
                nxt.rvalid = 1'b0;
                if (axi_resp.rlast) begin
                    rd_busy = 1'b0;
                end else begin
                    rd_addr = wrap_step(rd_addr, rd_len);
                    rd_left = rd_left - cbus_pkg::mlen_t'(1);
                end
            end
            if (rd_busy && !nxt.rvalid && no_stall()) begin
                nxt.rvalid = 1'b1;
                nxt.rdata  = read_word(rd_addr);
                nxt.rlast  = rd_left == '0;
            end

            if (axi_resp.awready && axi_req.awvalid) begin
                wr_busy = 1'b1;
                wr_addr = axi_req.awaddr;
                wr_len  = axi_req.awlen;
            end
            if (axi_resp.wready && axi_req.wvalid) begin
                write_word(wr_addr, axi_req.wdata, axi_req.wstrb);
                wr_addr = wrap_step(wr_addr, wr_len);
                if (axi_req.wlast) begin
                    wr_busy = 1'b0;
                    b_due   = 1'b1;
                end
            end
            if (axi_resp.bvalid && axi_req.bready) begin
                nxt.bvalid = 1'b0;
            end
            if (b_due && !nxt.bvalid && no_stall()) begin
                nxt.bvalid = 1'b1;
                b_due      = 1'b0;
            end

            nxt.arready = !rd_busy && no_stall();
            nxt.awready = !wr_busy && !b_due && !nxt.bvalid && no_stall();
            nxt.wready  = wr_busy && no_stall();   // data only after its address.
        end
        axi_resp <= nxt;
    end

endmodule

`default_nettype wire

/* verification/tb_cbus_axi.sv */
`default_nettype none

module tb_cbus_axi;
    timeunit 1ns;
    timeprecision 100ps;

    logic                 aclk;
    logic                 aresetn;
    cbus_pkg::cbus_req_t  ireq;
    cbus_pkg::cbus_req_t  dreq;
    cbus_pkg::cbus_resp_t iresp;
    cbus_pkg::cbus_resp_t dresp;
    cbus_pkg::axi_req_t   axi_req;
    cbus_pkg::axi_resp_t  axi_resp;

    logic [31:0] shadow [logic [29:0]];   // what memory should hold.
    logic [31:0] exp_idata;
    logic [31:0] exp_ddata;
    logic [31:0] salt;
    logic        i_busy;
    logic        d_busy;
    logic        i_final;       // waiting on the last beat.
    logic        d_final;
    logic        contend;       // both masters keep requesting.
    logic        last_winner;   // 1 when the data master finished last.
    int          data_errors;
    int          proto_errors;

    cbus_axi_top cbus_axi_top_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .ireq     (ireq),
        .iresp    (iresp),
        .dreq     (dreq),
        .dresp    (dresp),
        .axi_req  (axi_req),
        .axi_resp (axi_resp)
    );

    axi_mem_model axi_mem_model_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .axi_req  (axi_req),
        .axi_resp (axi_resp)
    );

    always #20 aclk = ~aclk;

    always @(posedge aclk) begin
        if (aresetn) begin
            last_winner <= 1'b1;   // instruction master goes first.
        end else if (iresp.last) begin
            last_winner <= 1'b0;
        end else if (dresp.last) begin
            last_winner <= 1'b1;
        end
    end

    function automatic logic [31:0] next_beat_addr(input logic [31:0] a, input int beats);
        logic [31:0] span;
        span = beats * 4;
        return (a & ~(span - 1)) | ((a + 4) & (span - 1));
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        if (shadow.exists(a[31:2])) begin
            return shadow[a[31:2]];
        end
        return '0;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] d,
                                                input logic [3:0] strb);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                old[i*8 +: 8] = d[i*8 +: 8];
            end
        end
        return old;
    endfunction

    function automatic logic [31:0] beat_data(input logic [31:0] a, input int k);
        return (a * 32'h9e3779b1) ^ {8'(k), salt[23:0]};
    endfunction

    task automatic next_cycle();
        @(posedge aclk);
        #2;
    endtask

    task automatic ifetch_read(input logic [31:0] addr, input int beats);
        logic [31:0] a;
        int          k;
        a          = addr;
        k          = 0;
        ireq       = '0;
        ireq.valid = 1'b1;
        ireq.size  = cbus_pkg::axi_size_word;
        ireq.addr  = addr;
        ireq.len   = cbus_pkg::mlen_t'(beats - 1);
        i_busy     = 1'b1;
        while (k < beats) begin
            exp_idata = shadow_word(a);
            i_final   = k == beats - 1;
            @(negedge aclk);
            if (iresp.ready) begin
                a = next_beat_addr(a, beats);
                k++;
            end
            next_cycle();
        end
        ireq.valid = 1'b0;
        i_busy     = 1'b0;
        i_final    = 1'b0;
    endtask

    task automatic data_access(input logic wr, input logic [31:0] addr, input int beats,
                               input logic [3:0] strb);
        logic [31:0] a;
        int          k;
        a             = addr;
        k             = 0;
        salt          = salt + 32'h0001_0003;
        dreq.valid    = 1'b1;
        dreq.is_write = wr;
        dreq.size     = cbus_pkg::axi_size_word;
        dreq.addr     = addr;
        dreq.len      = cbus_pkg::mlen_t'(beats - 1);
        d_busy        = 1'b1;
        while (k < beats) begin
            dreq.data   = beat_data(a, k);   // next word after each acknowledge.
            dreq.strobe = strb;
            exp_ddata   = shadow_word(a);
            d_final     = k == beats - 1;
            @(negedge aclk);
            if (dresp.ready) begin
                if (wr) begin
                    shadow[a[31:2]] = merge_bytes(shadow_word(a), dreq.data, strb);
                end
                a = next_beat_addr(a, beats);
                k++;
            end
            next_cycle();
        end
        dreq    = '0;
        d_busy  = 1'b0;
        d_final = 1'b0;
    endtask

    // nothing moves during reset or in the cycle after it.
    reset_quiet: assert property (@(posedge aclk) $past(aresetn) |->
        !(axi_req.arvalid || axi_req.awvalid || axi_req.wvalid || axi_req.rready ||
          axi_req.bready || iresp.ready || iresp.last || dresp.ready || dresp.last))
    else begin
        proto_errors++;
        $display("%0t: a valid, ready or last was high during or right after reset", $time);
    end

    ar_hold: assert property (@(posedge aclk) disable iff (aresetn)
        axi_req.arvalid && !axi_resp.arready |=> axi_req.arvalid &&
        $stable({axi_req.araddr, axi_req.arlen, axi_req.arsize, axi_req.arburst}))
    else begin
        proto_errors++;
        $display("%0t: arvalid dropped or AR fields changed before arready", $time);
    end

    aw_hold: assert property (@(posedge aclk) disable iff (aresetn)
        axi_req.awvalid && !axi_resp.awready |=> axi_req.awvalid &&
        $stable({axi_req.awaddr, axi_req.awlen, axi_req.awsize, axi_req.awburst}))
    else begin
        proto_errors++;
        $display("%0t: awvalid dropped or AW fields changed before awready", $time);
    end

    w_hold: assert property (@(posedge aclk) disable iff (aresetn)
        axi_req.wvalid && !axi_resp.wready |=> axi_req.wvalid &&
        $stable({axi_req.wdata, axi_req.wstrb, axi_req.wlast}))
    else begin
        proto_errors++;
        $display("%0t: wvalid dropped or W fields changed before wready", $time);
    end

    // zero id, word beats, wrap bursts.
    ar_attr_check: assert property (@(posedge aclk) disable iff (aresetn)
        axi_req.arvalid |->
        {axi_req.arid, axi_req.arsize, axi_req.arburst} == {4'h0, 3'b010, 2'b10})
    else begin
        data_errors++;
        $display("[FAIL] %0t arid/arsize/arburst expected %h got %h", $time,
                 {4'h0, 3'b010, 2'b10}, {axi_req.arid, axi_req.arsize, axi_req.arburst});
    end

    aw_attr_check: assert property (@(posedge aclk) disable iff (aresetn)
        axi_req.awvalid |->
        {axi_req.awid, axi_req.awsize, axi_req.awburst} == {4'h0, 3'b010, 2'b10})
    else begin
        data_errors++;
        $display("[FAIL] %0t awid/awsize/awburst expected %h got %h", $time,
                 {4'h0, 3'b010, 2'b10}, {axi_req.awid, axi_req.awsize, axi_req.awburst});
    end

    wid_check: assert property (@(posedge aclk) disable iff (aresetn)
        axi_req.wvalid |-> axi_req.wid == 4'h0)
    else begin
        data_errors++;
        $display("[FAIL] %0t wid expected %h got %h", $time, 4'h0, axi_req.wid);
    end

    idata_check: assert property (@(posedge aclk) disable iff (aresetn)
        iresp.ready |-> iresp.data == exp_idata)
    else begin
        data_errors++;
        $display("[FAIL] %0t iresp.data expected %h got %h", $time, exp_idata, iresp.data);
    end

    ddata_check: assert property (@(posedge aclk) disable iff (aresetn)
        dresp.ready && !dreq.is_write |-> dresp.data == exp_ddata)
    else begin
        data_errors++;
        $display("[FAIL] %0t dresp.data expected %h got %h", $time, exp_ddata, dresp.data);
    end

    ilast_check: assert property (@(posedge aclk) disable iff (aresetn)
        iresp.ready |-> iresp.last == i_final)
    else begin
        data_errors++;
        $display("[FAIL] %0t iresp.last expected %b got %b", $time, i_final, iresp.last);
    end

    dlast_check: assert property (@(posedge aclk) disable iff (aresetn)
        dresp.ready |-> dresp.last == d_final)
    else begin
        data_errors++;
        $display("[FAIL] %0t dresp.last expected %b got %b", $time, d_final, dresp.last);
    end

    // the master without the grant sees all zero.
    i_owner_check: assert property (@(posedge aclk) disable iff (aresetn)
        iresp.ready |-> i_busy && dresp == '0)
    else begin
        proto_errors++;
        $display("%0t: an instruction beat came without a request or leaked to the data side",
                 $time);
    end

    d_owner_check: assert property (@(posedge aclk) disable iff (aresetn)
        dresp.ready |-> d_busy && iresp == '0)
    else begin
        proto_errors++;
        $display("%0t: a data beat came without a request or leaked to the instruction side",
                 $time);
    end

    turn_check: assert property (@(posedge aclk) disable iff (aresetn)
        contend && (iresp.last || dresp.last) |-> iresp.last == last_winner)
    else begin
        proto_errors++;
        $display("%0t: the same master completed twice in a row under contention", $time);
    end

    initial begin
        aclk         = 1'b0;
        aresetn      = 1'b1;
        ireq         = '0;
        dreq         = '0;
        exp_idata    = '0;
        exp_ddata    = '0;
        salt         = '0;
        i_busy       = 1'b0;
        d_busy       = 1'b0;
        i_final      = 1'b0;
        d_final      = 1'b0;
        contend      = 1'b0;
        data_errors  = 0;
        proto_errors = 0;

        // both masters already request while reset is held.
        ireq.valid    = 1'b1;
        ireq.size     = cbus_pkg::axi_size_word;
        ireq.addr     = 32'h0000_0100;
        ireq.len      = cbus_pkg::mlen_t'(3);
        dreq.valid    = 1'b1;
        dreq.is_write = 1'b1;
        dreq.size     = cbus_pkg::axi_size_word;
        dreq.addr     = 32'h0000_0040;
        dreq.strobe   = 4'hf;
        repeat (8) @(posedge aclk);
        #2;
        aresetn = 1'b0;
        ireq    = '0;
        dreq    = '0;
        repeat (2) next_cycle();

        data_access(1'b1, 32'h0000_0040, 1, 4'hf);
        data_access(1'b0, 32'h0000_0040, 1, 4'h0);
        data_access(1'b1, 32'h0000_0108, 4, 4'hf);   // starts mid-line and wraps.
        data_access(1'b0, 32'h0000_0100, 4, 4'h0);
        data_access(1'b1, 32'h0000_0200, 1, 4'hf);
        data_access(1'b1, 32'h0000_0200, 1, 4'b0101);
        data_access(1'b0, 32'h0000_0200, 1, 4'h0);

        // random bursts, each pair in its own 64-byte block.
        for (int n = 0; n < 12; n++) begin
            int          beats;
            logic [31:0] base;
            beats = 1 << ($urandom % 5);
            base  = 32'h0000_1000 + n * 64;
            data_access(1'b1, base + ($urandom % beats) * 4, beats, 4'hf);
            data_access(1'b0, base + ($urandom % beats) * 4, beats, 4'h0);
        end

        contend = 1'b1;
        fork
            begin
                for (int n = 0; n < 8; n++) begin
                    ifetch_read(32'h0000_0100 + (n % 4) * 4, 4);
                end
                contend = 1'b0;
            end
            begin
                for (int n = 0; n < 8; n++) begin
                    data_access(1'b1, 32'h0000_3000 + n * 16, 4, 4'hf);
                end
                contend = 1'b0;
            end
        join
        data_access(1'b0, 32'h0000_3000, 4, 4'h0);
        data_access(1'b0, 32'h0000_3070, 4, 4'h0);

        repeat (4) next_cycle();
        $display("checks done: %0d data errors, %0d protocol errors", data_errors, proto_errors);
        if (data_errors == 0 && proto_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // 60 bursts of 16 beats plus reset slack, 1000 cycles or 40 us.
    initial begin
        repeat (60 * 16 + 40) @(posedge aclk);
        $display("watchdog expired before the test sequence finished");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
hw/cbus_pkg.sv
hw/cbus_arbiter.sv
hw/cbus_to_axi.sv
hw/cbus_axi_top.sv
verification/axi_mem_model.sv
verification/tb_cbus_axi.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_cbus_axi \
    -f tb.f -o tb_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
